//--- rv64_decode.f
+incdir+source
+incdir+test
source/rv64_decode_pkg.sv
source/decode_if.sv
source/imm_gen.sv
source/branch_unit.sv
source/inst_decoder.sv
source/regfile.sv
source/issue_reg.sv
source/decode_stage.sv
test/tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= rv64_decode.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard source/*.sv source/*.svh test/*.sv test/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/decode_cases.svh
`ifndef DECODE_CASES_SVH
`define DECODE_CASES_SVH

// columns: inst, pc, wb_we, wb_addr, wb_data,
//   op1, op2, alu_sel, word, rd_we, rd, mem_re, mem_we, mem_wdata, size, unsigned,
//   jump, target, illegal
localparam int N_CASES = 30;

localparam case_t CASES [N_CASES] = '{
  // add x6,x1,x2 / sub x7,x1,x2 / mulw x8,x1,x2
  '{32'h00208333, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, -64'd3, 15'h0001, 1'b0, 1'b1, 5'd6, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h402083B3, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, -64'd3, 15'h0002, 1'b0, 1'b1, 5'd7, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h0220843B, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, -64'd3, 15'h0400, 1'b1, 1'b1, 5'd8, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  // addi x9,x2,-5 / srai x10,x5,63 / sraiw x11,x1,3
  '{32'hFFB10493, 64'h2000, 1'b0, 5'd0, 64'h0,
    -64'd3, -64'd5, 15'h0001, 1'b0, 1'b1, 5'd9, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h43F2D513, 64'h2000, 1'b0, 5'd0, 64'h0,
    {1'b1, 63'h0}, 64'h43F, 15'h0200, 1'b0, 1'b1, 5'd10, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b0, 64'h0, 1'b0},
  '{32'h4030D59B, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, 64'h403, 15'h0200, 1'b1, 1'b1, 5'd11, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  // slli with reserved shift bits set
  '{32'h80109613, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h0, -64'd2047, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b1},
  // ld x13,16(x4) / lhu x14,-2(x4) / sw x2,8(x4)
  '{32'h01023683, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h1000, 64'd16, 15'h0001, 1'b0, 1'b1, 5'd13, 1'b1, 1'b0, 64'h0, 2'd3, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'hFFE25703, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h1000, -64'd2, 15'h0001, 1'b0, 1'b1, 5'd14, 1'b1, 1'b0, 64'h0, 2'd1, 1'b1, 1'b0, 64'h0, 1'b0},
  '{32'h00222423, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h1000, 64'd8, 15'h0001, 1'b0, 1'b0, 5'd0, 1'b0, 1'b1, -64'd3, 2'd2, 1'b0, 1'b0, 64'h0, 1'b0},
  // branches with offset 16: beq, bne on x1/x3, then blt..bgeu on x2/x1
  '{32'h00308863, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, 64'd100, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b1, 64'h2010, 1'b0},
  '{32'h00309863, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, 64'd100, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h00114863, 64'h2000, 1'b0, 5'd0, 64'h0,
    -64'd3, 64'd100, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b1, 64'h2010, 1'b0},
  '{32'h00115863, 64'h2000, 1'b0, 5'd0, 64'h0,
    -64'd3, 64'd100, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h00116863, 64'h2000, 1'b0, 5'd0, 64'h0,
    -64'd3, 64'd100, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h00117863, 64'h2000, 1'b0, 5'd0, 64'h0,
    -64'd3, 64'd100, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b1, 64'h2010, 1'b0},
  // the same six on x1/x2, where each condition flips
  '{32'h00208863, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, -64'd3, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h00209863, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, -64'd3, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b1, 64'h2010, 1'b0},
  '{32'h0020C863, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, -64'd3, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h0020D863, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, -64'd3, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b1, 64'h2010, 1'b0},
  '{32'h0020E863, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, -64'd3, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b1, 64'h2010, 1'b0},
  '{32'h0020F863, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'd100, -64'd3, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  // jal x1,+8 / jalr x0,5(x1)
  '{32'h008000EF, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h2000, 64'd4, 15'h0001, 1'b0, 1'b1, 5'd1, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b1, 64'h2008, 1'b0},
  '{32'h00508067, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h2000, 64'd4, 15'h0001, 1'b0, 1'b1, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b1, 64'h68, 1'b0},
  // lui x15,0x80000 / auipc x16,1
  '{32'h800007B7, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h0, {32'hFFFF_FFFF, 32'h8000_0000}, 15'h0001, 1'b0, 1'b1, 5'd15, 1'b0, 1'b0, 64'h0,
    2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h00001817, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h2000, 64'h1000, 15'h0001, 1'b0, 1'b1, 5'd16, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b0, 64'h0, 1'b0},
  // ecall and an unknown opcode
  '{32'h00000073, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h0, 64'h0, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b1},
  '{32'h0000007F, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h0, 64'h0, 15'h0000, 1'b0, 1'b0, 5'd0, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b1},
  // add x17,x0,x1 after x0 was written / addi x18,x20,0 with x20 written alongside
  '{32'h001008B3, 64'h2000, 1'b0, 5'd0, 64'h0,
    64'h0, 64'd100, 15'h0001, 1'b0, 1'b1, 5'd17, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0},
  '{32'h000A0913, 64'h2000, 1'b1, 5'd20, 64'h1234,
    64'h1234, 64'h0, 15'h0001, 1'b0, 1'b1, 5'd18, 1'b0, 1'b0, 64'h0, 2'd0, 1'b0,
    1'b0, 64'h0, 1'b0}
};

`endif

//--- test/tb_decode_stage.sv
`timescale 1ns/1ns
`include "rv64_decode_defs.svh"

module tb_decode_stage;

  typedef struct packed {
    logic [31:0]          inst;
    logic [63:0]          pc;
    logic                 wb_we;
    logic [4:0]           wb_addr;
    logic [63:0]          wb_data;
    logic [63:0]          op1;
    logic [63:0]          op2;
    logic [`ALU_OP_W-1:0] alu_sel;
    logic                 word;
    logic                 rd_we;
    logic [4:0]           rd_addr;
    logic                 mem_re;
    logic                 mem_we;
    logic [63:0]          mem_wdata;
    logic [1:0]           mem_size;
    logic                 mem_unsigned;
    logic                 jump;
    logic [63:0]          target;
    logic                 illegal;
  } case_t;

`include "decode_cases.svh"

  localparam int RESET_CYCLES = 5;
  localparam int TIMEOUT = 40 * N_CASES + RESET_CYCLES + 20;

  logic                 clk;
  logic                 reset_i;
  logic                 inst_valid_i;
  logic                 inst_ready_o;
  logic [`XLEN-1:0]     pc_i;
  logic [31:0]          inst_i;
  logic                 wb_we_i;
  logic [4:0]           wb_addr_i;
  logic [`XLEN-1:0]     wb_data_i;
  logic                 out_valid_o;
  logic                 out_ready_i;
  logic [`XLEN-1:0]     op1_o;
  logic [`XLEN-1:0]     op2_o;
  logic [`ALU_OP_W-1:0] alu_sel_o;
  logic                 alu_word_o;
  logic                 rd_we_o;
  logic [4:0]           rd_addr_o;
  logic                 mem_re_o;
  logic                 mem_we_o;
  logic [`XLEN-1:0]     mem_wdata_o;
  logic [1:0]           mem_size_o;
  logic                 mem_unsigned_o;
  logic                 jump_o;
  logic [`XLEN-1:0]     jump_target_o;
  logic                 illegal_o;

  integer seed = 32'h5019_1dc3;
  int     errors = 0;
  int     recv = 0;
  int     cycles = 0;
  bit     stalls_on = 1'b0;

  // register preload, x0 write included on purpose
  logic [4:0]  pre_addr [6] = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd0};
  logic [63:0] pre_data [6] = '{64'd100, -64'd3, 64'd100, 64'h1000, {1'b1, 63'h0}, 64'hDEAD};

  decode_stage dut0 (.*);

  always #5 clk = ~clk;

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_row(input case_t c);
    compare_field("op1_o", op1_o, c.op1);
    compare_field("op2_o", op2_o, c.op2);
    compare_field("alu_sel_o", 64'(alu_sel_o), 64'(c.alu_sel));
    compare_field("alu_word_o", 64'(alu_word_o), 64'(c.word));
    compare_field("rd_we_o", 64'(rd_we_o), 64'(c.rd_we));
    compare_field("rd_addr_o", 64'(rd_addr_o), 64'(c.rd_addr));
    compare_field("mem_re_o", 64'(mem_re_o), 64'(c.mem_re));
    compare_field("mem_we_o", 64'(mem_we_o), 64'(c.mem_we));
    compare_field("mem_wdata_o", mem_wdata_o, c.mem_wdata);
    compare_field("mem_size_o", 64'(mem_size_o), 64'(c.mem_size));
    compare_field("mem_unsigned_o", 64'(mem_unsigned_o), 64'(c.mem_unsigned));
    compare_field("jump_o", 64'(jump_o), 64'(c.jump));
    compare_field("jump_target_o", jump_target_o, c.target);
    compare_field("illegal_o", 64'(illegal_o), 64'(c.illegal));
  endtask

  // ==========================================================================
  // execute side: random stalls and output monitor
  // ==========================================================================
  always @(posedge clk) begin
    if (stalls_on) begin
      out_ready_i <= (($random(seed) & 3) != 0);
    end
  end

  // sampled mid-cycle, where every output is settled
  always @(negedge clk) begin
    if (!reset_i && out_valid_o) begin
      if (recv >= N_CASES) begin
        $display("output valid after the last row was already received");
        errors++;
      end else begin
        compare_row(CASES[recv]);
        if (out_ready_i) begin
          recv++;
        end else if (inst_ready_o !== 1'b0) begin
          $display("Fail at %0t ns: inst_ready_o = %b, expected 0", $time, inst_ready_o);
          errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles with %0d of %0d rows received",
               cycles, recv, N_CASES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ==========================================================================
  // input side
  // ==========================================================================
  initial begin
    clk          = 1'b0;
    reset_i      <= 1'b1;
    inst_valid_i <= 1'b0;
    pc_i         <= '0;
    inst_i       <= '0;
    wb_we_i      <= 1'b0;
    wb_addr_i    <= '0;
    wb_data_i    <= '0;
    out_ready_i  <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;

    @(negedge clk);
    compare_field("out_valid_o", 64'(out_valid_o), 64'h0);
    compare_field("rd_we_o", 64'(rd_we_o), 64'h0);
    compare_field("illegal_o", 64'(illegal_o), 64'h0);

    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      wb_we_i   <= 1'b1;
      wb_addr_i <= pre_addr[i];
      wb_data_i <= pre_data[i];
    end
    @(posedge clk);
    wb_we_i   <= 1'b0;
    stalls_on <= 1'b1;

    // back to back, next row goes out on the edge that takes this one
    for (int i = 0; i < N_CASES; i++) begin
      // drain first, so the transfer and the writeback share one edge
      if (CASES[i].wb_we) begin
        inst_valid_i <= 1'b0;
        wb_we_i      <= 1'b0;
        @(negedge clk);
        while (out_valid_o) @(negedge clk);
        @(posedge clk);
      end
      inst_valid_i <= 1'b1;
      inst_i       <= CASES[i].inst;
      pc_i         <= CASES[i].pc;
      wb_we_i      <= CASES[i].wb_we;
      wb_addr_i    <= CASES[i].wb_addr;
      wb_data_i    <= CASES[i].wb_data;
      @(negedge clk);
      while (!inst_ready_o) @(negedge clk);
      @(posedge clk);
    end
    inst_valid_i <= 1'b0;
    wb_we_i      <= 1'b0;

    while (recv < N_CASES) @(posedge clk);
    repeat (3) @(posedge clk);

    $display("decode stage test done: %0d rows, %0d errors", recv, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ns
`include "rv64_decode_defs.svh"

module decode_stage (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 inst_valid_i,
  output logic                 inst_ready_o,
  input  logic [`XLEN-1:0]     pc_i,
  input  logic [31:0]          inst_i,
  input  logic                 wb_we_i,
  input  logic [4:0]           wb_addr_i,
  input  logic [`XLEN-1:0]     wb_data_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [`XLEN-1:0]     op1_o,
  output logic [`XLEN-1:0]     op2_o,
  output logic [`ALU_OP_W-1:0] alu_sel_o,
  output logic                 alu_word_o,
  output logic                 rd_we_o,
  output logic [4:0]           rd_addr_o,
  output logic                 mem_re_o,
  output logic                 mem_we_o,
  output logic [`XLEN-1:0]     mem_wdata_o,
  output logic [1:0]           mem_size_o,
  output logic                 mem_unsigned_o,
  output logic                 jump_o,
  output logic [`XLEN-1:0]     jump_target_o,
  output logic                 illegal_o
);

  logic [4:0]       raddr1;
  logic [4:0]       raddr2;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;

  decode_if dec_if (.clk(clk));

  regfile u_regfile (
    .clk      (clk),
    .reset_i  (reset_i),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wb_we_i),
    .waddr_i  (wb_addr_i),
    .wdata_i  (wb_data_i)
  );

  inst_decoder u_inst_decoder (
    .pc_i     (pc_i),
    .inst_i   (inst_i),
    .valid_i  (inst_valid_i),
    .ready_o  (inst_ready_o),
    .raddr1_o (raddr1),
    .raddr2_o (raddr2),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .dec      (dec_if.producer)
  );

  // execute side sees only the registered copy
  issue_reg u_issue_reg (
    .clk            (clk),
    .reset_i        (reset_i),
    .dec            (dec_if.consumer),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .op1_o          (op1_o),
    .op2_o          (op2_o),
    .alu_sel_o      (alu_sel_o),
    .alu_word_o     (alu_word_o),
    .rd_we_o        (rd_we_o),
    .rd_addr_o      (rd_addr_o),
    .mem_re_o       (mem_re_o),
    .mem_we_o       (mem_we_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_size_o     (mem_size_o),
    .mem_unsigned_o (mem_unsigned_o),
    .jump_o         (jump_o),
    .jump_target_o  (jump_target_o),
    .illegal_o      (illegal_o)
  );

endmodule

//--- source/issue_reg.sv
`timescale 1ns/1ns
`include "rv64_decode_defs.svh"

module issue_reg (
  input  logic                 clk,
  input  logic                 reset_i,
  decode_if.consumer           dec,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [`XLEN-1:0]     op1_o,
  output logic [`XLEN-1:0]     op2_o,
  output logic [`ALU_OP_W-1:0] alu_sel_o,
  output logic                 alu_word_o,
  output logic                 rd_we_o,
  output logic [4:0]           rd_addr_o,
  output logic                 mem_re_o,
  output logic                 mem_we_o,
  output logic [`XLEN-1:0]     mem_wdata_o,
  output logic [1:0]           mem_size_o,
  output logic                 mem_unsigned_o,
  output logic                 jump_o,
  output logic [`XLEN-1:0]     jump_target_o,
  output logic                 illegal_o
);

  logic load;

  // free when empty or draining this cycle
  assign dec.ready = ~out_valid_o | out_ready_i;
  assign load      = dec.valid & dec.ready;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_valid_o    <= 1'b0;
      op1_o          <= '0;
      op2_o          <= '0;
      alu_sel_o      <= '0;
      alu_word_o     <= 1'b0;
      rd_we_o        <= 1'b0;
      rd_addr_o      <= '0;
      mem_re_o       <= 1'b0;
      mem_we_o       <= 1'b0;
      mem_wdata_o    <= '0;
      mem_size_o     <= '0;
      mem_unsigned_o <= 1'b0;
      jump_o         <= 1'b0;
      jump_target_o  <= '0;
      illegal_o      <= 1'b0;
    end else if (load) begin
      out_valid_o    <= 1'b1;
      op1_o          <= dec.op1;
      op2_o          <= dec.op2;
      alu_sel_o      <= dec.alu_sel;
      alu_word_o     <= dec.alu_word;
      rd_we_o        <= dec.rd_we;
      rd_addr_o      <= dec.rd_addr;
      mem_re_o       <= dec.mem_re;
      mem_we_o       <= dec.mem_we;
      mem_wdata_o    <= dec.mem_wdata;
      mem_size_o     <= dec.mem_size;
      mem_unsigned_o <= dec.mem_unsigned;
      jump_o         <= dec.jump;
      jump_target_o  <= dec.jump_target;
      illegal_o      <= dec.illegal;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  // stalled entry stays put until taken
  a_hold: assert property (@(posedge clk) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o &&
    $stable({op1_o, op2_o, alu_sel_o, alu_word_o, rd_we_o, rd_addr_o, mem_re_o, mem_we_o,
             mem_wdata_o, mem_size_o, mem_unsigned_o, jump_o, jump_target_o, illegal_o}));

  a_reset_empty: assert property (@(posedge clk) reset_i |=> !out_valid_o);

endmodule

//--- source/regfile.sv
`timescale 1ns/1ns
`include "rv64_decode_defs.svh"

module regfile (
  input  logic             clk,
  input  logic             reset_i,
  input  logic [4:0]       raddr1_i,
  input  logic [4:0]       raddr2_i,
  output logic [`XLEN-1:0] rdata1_o,
  output logic [`XLEN-1:0] rdata2_o,
  input  logic             we_i,
  input  logic [4:0]       waddr_i,
  input  logic [`XLEN-1:0] wdata_i
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // same-cycle writeback wins over the stored value
  function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end else if (we_i && waddr_i == addr) begin
      return wdata_i;
    end
    return regs[addr];
  endfunction

  assign rdata1_o = read_port(raddr1_i);
  assign rdata2_o = read_port(raddr2_i);

  a_we_known: assert property (@(posedge clk) disable iff (reset_i) !$isunknown(we_i));

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/1ns
`include "rv64_decode_defs.svh"

module inst_decoder (
  input  logic [`XLEN-1:0] pc_i,
  input  logic [31:0]      inst_i,
  input  logic             valid_i,
  output logic             ready_o,
  output logic [4:0]       raddr1_o,
  output logic [4:0]       raddr2_o,
  input  logic [`XLEN-1:0] rdata1_i,
  input  logic [`XLEN-1:0] rdata2_i,
  decode_if.producer       dec
);
  import rv64_decode_pkg::*;

  inst_u                inst;
  logic [6:0]           opcode;
  logic [2:0]           f3;
  logic [6:0]           f7;
  logic [6:0]           shift_hi;
  logic [`XLEN-1:0]     imm;
  logic [`ALU_OP_W-1:0] f3_sel;
  logic [`ALU_OP_W-1:0] alu_sel;
  logic                 legal;
  logic                 word_f3;
  logic                 is_op, is_op_32, is_op_imm, is_op_imm_32;
  logic                 is_load, is_store, is_branch;
  logic                 is_jal, is_jalr, is_lui, is_auipc;
  logic                 use_rs1, use_rs2;

  assign inst   = inst_i;
  assign opcode = inst.r.opcode;
  assign f3     = inst.r.funct3;
  assign f7     = inst.r.funct7;

  assign is_op        = (opcode == `OPC_OP);
  assign is_op_32     = (opcode == `OPC_OP_32);
  assign is_op_imm    = (opcode == `OPC_OP_IMM);
  assign is_op_imm_32 = (opcode == `OPC_OP_IMM_32);
  assign is_load      = (opcode == `OPC_LOAD);
  assign is_store     = (opcode == `OPC_STORE);
  assign is_branch    = (opcode == `OPC_BRANCH);
  assign is_jal       = (opcode == `OPC_JAL);
  assign is_jalr      = (opcode == `OPC_JALR);
  assign is_lui       = (opcode == `OPC_LUI);
  assign is_auipc     = (opcode == `OPC_AUIPC);

  // shamt[5] sits in the funct7 slot for 64-bit shifts
  assign shift_hi = is_op_imm_32 ? f7 : {inst_i[31:26], 1'b0};
  assign word_f3  = (f3 == `F3_ADD) || (f3 == `F3_SLL) || (f3 == `F3_SRL);

  // ========================================================================
  // alu select
  // ========================================================================

  // base integer op named by funct3 alone
  always_comb begin
    f3_sel = '0;
    case (f3)
      `F3_ADD:  f3_sel[`ALU_ADD]  = 1'b1;
      `F3_SLL:  f3_sel[`ALU_SLL]  = 1'b1;
      `F3_SLT:  f3_sel[`ALU_SLT]  = 1'b1;
      `F3_SLTU: f3_sel[`ALU_SLTU] = 1'b1;
      `F3_XOR:  f3_sel[`ALU_XOR]  = 1'b1;
      `F3_SRL:  f3_sel[`ALU_SRL]  = 1'b1;
      `F3_OR:   f3_sel[`ALU_OR]   = 1'b1;
      default:  f3_sel[`ALU_AND]  = 1'b1;
    endcase
  end

  always_comb begin
    legal   = 1'b1;
    alu_sel = '0;
    case (opcode)
      `OPC_OP, `OPC_OP_32: begin
        if (f7 == `F7_MULDIV) begin
          case (f3)
            `F3_MUL:  alu_sel[`ALU_MUL]  = 1'b1;
            `F3_DIV:  alu_sel[`ALU_DIV]  = 1'b1;
            `F3_DIVU: alu_sel[`ALU_DIVU] = 1'b1;
            `F3_REM:  alu_sel[`ALU_REM]  = 1'b1;
            `F3_REMU: alu_sel[`ALU_REMU] = 1'b1;
            // mulh family has no select bit
            default:  legal = 1'b0;
          endcase
        end else if (f7 == `F7_ALT && f3 == `F3_ADD) begin
          alu_sel[`ALU_SUB] = 1'b1;
        end else if (f7 == `F7_ALT && f3 == `F3_SRL) begin
          alu_sel[`ALU_SRA] = 1'b1;
        end else if (f7 == `F7_BASE && (is_op || word_f3)) begin
          alu_sel = f3_sel;
        end else begin
          legal = 1'b0;
        end
      end
      `OPC_OP_IMM, `OPC_OP_IMM_32: begin
        if (f3 == `F3_SLL || f3 == `F3_SRL) begin
          if (shift_hi == `F7_BASE) begin
            alu_sel = f3_sel;
          end else if (shift_hi == `F7_ALT && f3 == `F3_SRL) begin
            alu_sel[`ALU_SRA] = 1'b1;
          end else begin
            legal = 1'b0;
          end
        end else if (is_op_imm_32 && f3 != `F3_ADD) begin
          legal = 1'b0;
        end else begin
          alu_sel = f3_sel;
        end
      end
      `OPC_LOAD: begin
        legal             = (f3 != 3'b111);
        alu_sel[`ALU_ADD] = 1'b1;
      end
      `OPC_STORE: begin
        legal             = ~f3[2];
        alu_sel[`ALU_ADD] = 1'b1;
      end
      // compare happens in the branch unit
      `OPC_BRANCH: legal = f3[2] | ~f3[1];
      `OPC_JALR: begin
        legal             = (f3 == `F3_JALR);
        alu_sel[`ALU_ADD] = 1'b1;
      end
      `OPC_JAL, `OPC_LUI, `OPC_AUIPC: alu_sel[`ALU_ADD] = 1'b1;
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      alu_sel = '0;
    end
  end

  // ========================================================================
  // operands, register and memory control
  // ========================================================================
  assign use_rs1 = legal & (is_op | is_op_32 | is_op_imm | is_op_imm_32 | is_load |
                            is_store | is_branch | is_jalr);
  assign use_rs2 = legal & (is_op | is_op_32 | is_store | is_branch);
  assign raddr1_o = use_rs1 ? inst.r.rs1 : 5'd0;
  assign raddr2_o = use_rs2 ? inst.r.rs2 : 5'd0;

  imm_gen u_imm_gen (
    .inst_i (inst),
    .imm_o  (imm)
  );

  always_comb begin
    if (is_auipc || is_jal || is_jalr) begin
      dec.op1 = pc_i;
    end else if (is_lui) begin
      dec.op1 = '0;
    end else begin
      dec.op1 = rdata1_i;
    end
  end

  always_comb begin
    if (is_jal || is_jalr) begin
      dec.op2 = `XLEN'(4);
    end else if (is_op_imm || is_op_imm_32 || is_load || is_store || is_lui || is_auipc) begin
      dec.op2 = imm;
    end else begin
      dec.op2 = rdata2_i;
    end
  end

  assign dec.alu_sel  = alu_sel;
  assign dec.alu_word = legal & (is_op_32 | is_op_imm_32);
  assign dec.rd_we    = legal & (is_op | is_op_32 | is_op_imm | is_op_imm_32 | is_load |
                                 is_lui | is_auipc | is_jal | is_jalr);
  assign dec.rd_addr  = dec.rd_we ? inst.r.rd : 5'd0;

  assign dec.mem_re       = legal & is_load;
  assign dec.mem_we       = legal & is_store;
  assign dec.mem_wdata    = dec.mem_we ? rdata2_i : '0;
  assign dec.mem_size     = (dec.mem_re | dec.mem_we) ? f3[1:0] : 2'd0;
  assign dec.mem_unsigned = dec.mem_re & f3[2];
  assign dec.illegal      = ~legal;

  branch_unit u_branch_unit (
    .pc_i       (pc_i),
    .rs1_data_i (rdata1_i),
    .rs2_data_i (rdata2_i),
    .imm_i      (imm),
    .funct3_i   (f3),
    .is_branch_i(legal & is_branch),
    .is_jal_i   (is_jal),
    .is_jalr_i  (legal & is_jalr),
    .jump_o     (dec.jump),
    .target_o   (dec.jump_target)
  );

  assign dec.valid = valid_i;
  assign ready_o   = dec.ready;

  // alu select is one-hot or empty
  a_sel_onehot: assert property (@(posedge dec.clk) dec.valid |-> $onehot0(dec.alu_sel));

endmodule

//--- source/branch_unit.sv
`timescale 1ns/1ns
`include "rv64_decode_defs.svh"

module branch_unit (
  input  logic [`XLEN-1:0] pc_i,
  input  logic [`XLEN-1:0] rs1_data_i,
  input  logic [`XLEN-1:0] rs2_data_i,
  input  logic [`XLEN-1:0] imm_i,
  input  logic [2:0]       funct3_i,
  input  logic             is_branch_i,
  input  logic             is_jal_i,
  input  logic             is_jalr_i,
  output logic             jump_o,
  output logic [`XLEN-1:0] target_o
);

  logic [`XLEN-1:0] diff;
  logic             same_sign;
  logic             eq;
  logic             lt_s;
  logic             lt_u;
  logic             cond;
  logic             br_taken;

  // one subtractor serves all three compares
  assign diff      = rs1_data_i - rs2_data_i;
  assign same_sign = (rs1_data_i[`XLEN-1] == rs2_data_i[`XLEN-1]);
  assign eq        = (diff == '0);
  assign lt_s = (rs1_data_i[`XLEN-1] & ~rs2_data_i[`XLEN-1]) | (same_sign & diff[`XLEN-1]);
  assign lt_u = (~rs1_data_i[`XLEN-1] & rs2_data_i[`XLEN-1]) | (same_sign & diff[`XLEN-1]);

  always_comb begin
    case (funct3_i)
      `F3_BEQ:  cond = eq;
      `F3_BNE:  cond = ~eq;
      `F3_BLT:  cond = lt_s;
      `F3_BGE:  cond = ~lt_s;
      `F3_BLTU: cond = lt_u;
      `F3_BGEU: cond = ~lt_u;
      default:  cond = 1'b0;
    endcase
  end

  assign br_taken = is_branch_i & cond;
  assign jump_o   = br_taken | is_jal_i | is_jalr_i;

  always_comb begin
    if (is_jalr_i) begin
      target_o = (rs1_data_i + imm_i) & ~`XLEN'(1);
    end else if (br_taken | is_jal_i) begin
      target_o = pc_i + imm_i;
    end else begin
      target_o = '0;
    end
  end

endmodule

//--- source/imm_gen.sv
`timescale 1ns/1ns
`include "rv64_decode_defs.svh"

module imm_gen (
  input  rv64_decode_pkg::inst_u inst_i,
  output logic [`XLEN-1:0]       imm_o
);

  // format follows from the opcode alone
  always_comb begin
    case (inst_i.r.opcode)
      `OPC_OP_IMM, `OPC_OP_IMM_32, `OPC_LOAD, `OPC_JALR: begin
        imm_o = {{(`XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
      end
      `OPC_STORE: begin
        imm_o = {{(`XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
      end
      `OPC_BRANCH: begin
        imm_o = {{(`XLEN-12){inst_i.b.imm12}}, inst_i.b.imm11, inst_i.b.imm10_5,
                 inst_i.b.imm4_1, 1'b0};
      end
      `OPC_LUI, `OPC_AUIPC: begin
        imm_o = {{(`XLEN-32){inst_i.u.imm[19]}}, inst_i.u.imm, 12'b0};
      end
      `OPC_JAL: begin
        imm_o = {{(`XLEN-20){inst_i.j.imm20}}, inst_i.j.imm19_12, inst_i.j.imm11,
                 inst_i.j.imm10_1, 1'b0};
      end
      // r-type and anything unknown
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

//--- source/decode_if.sv
`timescale 1ns/1ns
`include "rv64_decode_defs.svh"

interface decode_if (
  input logic clk
);
  logic                 valid;
  logic                 ready;
  logic [`XLEN-1:0]     op1;
  logic [`XLEN-1:0]     op2;
  logic [`ALU_OP_W-1:0] alu_sel;
  logic                 alu_word;
  logic                 rd_we;
  logic [4:0]           rd_addr;
  logic                 mem_re;
  logic                 mem_we;
  logic [`XLEN-1:0]     mem_wdata;
  logic [1:0]           mem_size;
  logic                 mem_unsigned;
  logic                 jump;
  logic [`XLEN-1:0]     jump_target;
  logic                 illegal;

  modport producer (
    input  clk, ready,
    output valid, op1, op2, alu_sel, alu_word, rd_we, rd_addr, mem_re, mem_we,
    output mem_wdata, mem_size, mem_unsigned, jump, jump_target, illegal
  );

  modport consumer (
    input  clk, valid, op1, op2, alu_sel, alu_word, rd_we, rd_addr, mem_re, mem_we,
    input  mem_wdata, mem_size, mem_unsigned, jump, jump_target, illegal,
    output ready
  );
endinterface

//--- source/rv64_decode_pkg.sv
package rv64_decode_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered across the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, six ways to read it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage

//--- source/rv64_decode_defs.svh
`ifndef RV64_DECODE_DEFS_SVH
`define RV64_DECODE_DEFS_SVH

`define XLEN 64

// major opcodes
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_32     7'b0111011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_BRANCH    7'b1100011
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111

// funct3 for integer ops
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SRL  3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// funct3 for muldiv
`define F3_MUL  3'b000
`define F3_DIV  3'b100
`define F3_DIVU 3'b101
`define F3_REM  3'b110
`define F3_REMU 3'b111

// funct3 for branches and jalr
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111
`define F3_JALR 3'b000

`define F7_BASE   7'b0000000
`define F7_ALT    7'b0100000
`define F7_MULDIV 7'b0000001

// one-hot alu select, bit positions
`define ALU_OP_W 15
`define ALU_ADD  0
`define ALU_SUB  1
`define ALU_SLT  2
`define ALU_SLTU 3
`define ALU_AND  4
`define ALU_OR   5
`define ALU_XOR  6
`define ALU_SLL  7
`define ALU_SRL  8
`define ALU_SRA  9
`define ALU_MUL  10
`define ALU_DIV  11
`define ALU_DIVU 12
`define ALU_REM  13
`define ALU_REMU 14

`endif
